/* rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Width of an instruction address in bits
`define RV_XLEN 32

// Number of direct-mapped BTB entries
// The index is taken from address bits just above the word offset
`define RV_BTB_ENTRIES 16

// Number of return addresses the RAS can hold before it wraps
`define RV_RAS_DEPTH 4

// Fetch address loaded into the PC register while arst_n is low
`define RV_RESET_PC 32'h0000_0000

`endif

/* rv_pkg.sv */
`include "rv_defs.svh"

package rv_pkg;

    // Next-PC source as seen by the PC register
    // SEQ steps to the next word, PREDICTED takes a predicted target and
    // REDIRECT takes a resolved target from a later stage
    typedef enum logic [1:0] {
        PC_SEL_SEQ       = 2'b00,
        PC_SEL_PREDICTED = 2'b01,
        PC_SEL_REDIRECT  = 2'b10
    } pc_sel_t;

    // One instruction address
    typedef logic [`RV_XLEN-1:0] addr_t;

endpackage

/* rv_btb.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_btb #(
    parameter int BTB_ENABLE = 1
) (
    input  logic          clk,
    input  logic          arst_n,
    input  rv_pkg::addr_t pc_if,
    input  logic          btb_upd_valid,
    input  rv_pkg::addr_t btb_upd_pc,
    input  rv_pkg::addr_t btb_upd_target,
    input  logic          btb_upd_taken,
    input  logic          btb_upd_is_return,
    output logic          btb_hit,
    output logic          btb_taken,
    output rv_pkg::addr_t btb_target,
    output logic          btb_is_return
);

    // Index sits right above the two byte-offset bits, the tag is everything above it
    localparam int IDX_W = $clog2(`RV_BTB_ENTRIES);
    localparam int TAG_W = `RV_XLEN - IDX_W - 2;

    if (BTB_ENABLE != 0) begin : g_btb
        logic [`RV_BTB_ENTRIES-1:0] valid;
        logic [TAG_W-1:0]           tag_mem    [`RV_BTB_ENTRIES];
        rv_pkg::addr_t              target_mem [`RV_BTB_ENTRIES];
        logic [1:0]                 cnt_mem    [`RV_BTB_ENTRIES];
        logic                       ret_mem    [`RV_BTB_ENTRIES];

        logic [IDX_W-1:0] lk_idx;
        logic [TAG_W-1:0] lk_tag;
        logic [IDX_W-1:0] upd_idx;
        logic [TAG_W-1:0] upd_tag;
        logic             upd_match;
        logic [1:0]       upd_cnt;

        assign lk_idx  = pc_if[IDX_W+1:2];
        assign lk_tag  = pc_if[`RV_XLEN-1:IDX_W+2];
        assign upd_idx = btb_upd_pc[IDX_W+1:2];
        assign upd_tag = btb_upd_pc[`RV_XLEN-1:IDX_W+2];

        // Lookup reads the table as it stood before this edge's update
        assign btb_hit       = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
        // Counter MSB set means 2 or 3, i.e. taken
        assign btb_taken     = btb_hit && cnt_mem[lk_idx][1];
        assign btb_target    = btb_hit ? target_mem[lk_idx] : '0;
        assign btb_is_return = btb_hit && ret_mem[lk_idx];

        // An update to the entry already holding this branch trains its counter
        assign upd_match = valid[upd_idx] && (tag_mem[upd_idx] == upd_tag);

        // Saturating 2-bit counter step
        always_comb begin
            upd_cnt = cnt_mem[upd_idx];
            if (btb_upd_taken && (upd_cnt != 2'd3)) begin
                upd_cnt = upd_cnt + 2'd1;
            end else if (!btb_upd_taken && (upd_cnt != 2'd0)) begin
                upd_cnt = upd_cnt - 2'd1;
            end
        end

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid <= '0;
            end else if (btb_upd_valid) begin
                valid[upd_idx] <= 1'b1;
            end
        end

        // A fresh allocation starts weakly taken regardless of the outcome
        always_ff @(posedge clk) begin
            if (btb_upd_valid) begin
                tag_mem[upd_idx]    <= upd_tag;
                target_mem[upd_idx] <= btb_upd_target;
                ret_mem[upd_idx]    <= btb_upd_is_return;
                cnt_mem[upd_idx]    <= upd_match ? upd_cnt : 2'd2;
            end
        end
    end else begin : g_no_btb
        // No table at all, so nothing ever hits
        assign btb_hit       = 1'b0;
        assign btb_taken     = 1'b0;
        assign btb_target    = '0;
        assign btb_is_return = 1'b0;
    end

endmodule

/* rv_ras.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_ras #(
    parameter int RAS_ENABLE = 1
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          ras_push,
    input  rv_pkg::addr_t ras_push_addr,
    input  logic          ras_pop,
    output logic          ras_valid,
    output rv_pkg::addr_t ras_target
);

    localparam int PTR_W = $clog2(`RV_RAS_DEPTH);
    localparam int CNT_W = $clog2(`RV_RAS_DEPTH + 1);

    if (RAS_ENABLE != 0) begin : g_ras
        localparam logic [PTR_W-1:0] LAST = PTR_W'(`RV_RAS_DEPTH - 1);
        localparam logic [CNT_W-1:0] FULL = CNT_W'(`RV_RAS_DEPTH);

        rv_pkg::addr_t    stack [`RV_RAS_DEPTH];
        logic [PTR_W-1:0] tos;
        logic [PTR_W-1:0] tos_inc;
        logic [PTR_W-1:0] tos_dec;
        logic [CNT_W-1:0] count;
        logic             pop_ok;

        // The pointer is circular so a push past the depth lands on the oldest entry
        assign tos_inc = (tos == LAST) ? '0 : tos + 1'b1;
        assign tos_dec = (tos == '0) ? LAST : tos - 1'b1;

        // Popping an empty stack is dropped
        assign pop_ok = ras_pop && (count != '0);

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                tos   <= '0;
                count <= '0;
            end else if (ras_push && !pop_ok) begin
                tos <= tos_inc;
                // Count saturates at the depth once the stack starts wrapping
                if (count != FULL) begin
                    count <= count + 1'b1;
                end
            end else if (pop_ok && !ras_push) begin
                tos   <= tos_dec;
                count <= count - 1'b1;
            end
        end

        // Push with pop rewrites the top slot and leaves pointer and count alone
        always_ff @(posedge clk) begin
            if (ras_push) begin
                stack[pop_ok ? tos : tos_inc] <= ras_push_addr;
            end
        end

        assign ras_valid  = (count != '0);
        assign ras_target = ras_valid ? stack[tos] : '0;
    end else begin : g_no_ras
        assign ras_valid  = 1'b0;
        assign ras_target = '0;
    end

endmodule

/* rv_if_id_buf.sv */
`timescale 1ns/1ps

module rv_if_id_buf (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          ras_valid,
    input  rv_pkg::addr_t ras_target,
    input  logic          btb_hit,
    input  logic          btb_is_return,
    output logic          ras_valid_id,
    output rv_pkg::addr_t ras_target_id,
    output logic          btb_hit_id,
    output logic          btb_is_return_id
);

    // Snapshot of what the predictors reported when the instruction now in ID
    // was fetched
    // A late RAS decision has to use these values and not the live ones, since the
    // stack may have been popped or pushed in between
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ras_valid_id     <= 1'b0;
            ras_target_id    <= '0;
            btb_hit_id       <= 1'b0;
            btb_is_return_id <= 1'b0;
        end else begin
            ras_valid_id     <= ras_valid;
            ras_target_id    <= ras_target;
            btb_hit_id       <= btb_hit;
            btb_is_return_id <= btb_is_return;
        end
    end

endmodule

/* rv_pc_sel.sv */
`timescale 1ns/1ps

module rv_pc_sel #(
    parameter int RAS_ENABLE = 1,
    parameter int BTB_ENABLE = 1
) (
    input  logic            mispredicted_mem,
    input  rv_pkg::addr_t   pc_redirect_target_mem,
    input  rv_pkg::pc_sel_t pc_sel_ex,
    input  rv_pkg::addr_t   pc_redirect_target_ex,
    input  rv_pkg::pc_sel_t pc_sel_id,
    input  rv_pkg::addr_t   pred_target_id,
    input  logic            ras_valid,
    input  rv_pkg::addr_t   ras_target,
    input  logic            is_jalr_id,
    input  logic            ras_valid_id,
    input  rv_pkg::addr_t   ras_target_id,
    input  logic            btb_hit,
    input  logic            btb_taken,
    input  rv_pkg::addr_t   btb_target,
    input  logic            btb_is_return,
    input  logic            btb_hit_id,
    input  logic            btb_is_return_id,
    output rv_pkg::pc_sel_t pc_sel,
    output rv_pkg::addr_t   pred_target,
    output rv_pkg::addr_t   pc_redirect_target,
    output logic            btb_pred_taken,
    output logic            ras_pred_taken
);

    rv_pkg::pc_sel_t pc_sel_pred;
    logic            ras_early;
    logic            ras_late;
    logic            ras_pred;
    logic            btb_pred;
    logic            id_pred;

    if (RAS_ENABLE != 0) begin : g_ras_pred
        // Each case checks stack validity from its own stage
        // Early case is a return the BTB already knows about, seen in IF
        assign ras_early = btb_hit && btb_is_return && ras_valid;
        // Late case is a JALR reaching ID that IF did not catch
        assign ras_late  = is_jalr_id && !(btb_hit_id && btb_is_return_id) && ras_valid_id;
        assign ras_pred  = ras_early || ras_late;
    end else begin : g_no_ras_pred
        assign ras_early = 1'b0;
        assign ras_late  = 1'b0;
        assign ras_pred  = 1'b0;
    end

    if (BTB_ENABLE != 0) begin : g_btb_pred
        assign btb_pred = btb_hit && btb_taken;
    end else begin : g_no_btb_pred
        assign btb_pred = 1'b0;
    end

    // A decoded instruction in ID outranks speculation about the one in IF
    assign id_pred = (pc_sel_id == rv_pkg::PC_SEL_PREDICTED);

    // Prediction arbitration, ID first, then RAS, then BTB, else ID as given
    always_comb begin
        if (id_pred) begin
            pc_sel_pred = pc_sel_id;
            pred_target = pred_target_id;
        end else if (ras_pred) begin
            pc_sel_pred = rv_pkg::PC_SEL_PREDICTED;
            // The late case must use the buffered top even if IF has its own early hit
            pred_target = ras_late ? ras_target_id : ras_target;
        end else if (btb_pred) begin
            pc_sel_pred = rv_pkg::PC_SEL_PREDICTED;
            pred_target = btb_target;
        end else begin
            pc_sel_pred = pc_sel_id;
            pred_target = pred_target_id;
        end
    end

    // Source flags for the hazard logic downstream
    // An early RAS hit counts as a BTB prediction even with the counter untrained
    // A late RAS prediction owns the fetch, so the IF-side flag stays low then
    assign btb_pred_taken = !id_pred && !ras_late && (btb_pred || ras_early);
    assign ras_pred_taken = !id_pred && ras_late;

    // Resolved redirects beat any prediction, and MEM is older than EX
    always_comb begin
        if (mispredicted_mem) begin
            pc_sel             = rv_pkg::PC_SEL_REDIRECT;
            pc_redirect_target = pc_redirect_target_mem;
        end else if (pc_sel_ex == rv_pkg::PC_SEL_REDIRECT) begin
            pc_sel             = rv_pkg::PC_SEL_REDIRECT;
            pc_redirect_target = pc_redirect_target_ex;
        end else begin
            pc_sel             = pc_sel_pred;
            pc_redirect_target = '0;
        end
    end

endmodule

/* rv_pc_gen.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module rv_pc_gen #(
    parameter int RAS_ENABLE = 1,
    parameter int BTB_ENABLE = 1
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            mispredicted_mem,
    input  rv_pkg::addr_t   pc_redirect_target_mem,
    input  rv_pkg::pc_sel_t pc_sel_ex,
    input  rv_pkg::addr_t   pc_redirect_target_ex,
    input  rv_pkg::pc_sel_t pc_sel_id,
    input  rv_pkg::addr_t   pred_target_id,
    input  logic            ras_valid,
    input  rv_pkg::addr_t   ras_target,
    input  logic            is_jalr_id,
    input  logic            ras_valid_id,
    input  rv_pkg::addr_t   ras_target_id,
    input  logic            btb_hit,
    input  logic            btb_taken,
    input  rv_pkg::addr_t   btb_target,
    input  logic            btb_is_return,
    input  logic            btb_hit_id,
    input  logic            btb_is_return_id,
    output rv_pkg::addr_t   pc_if,
    output rv_pkg::pc_sel_t pc_sel,
    output logic            btb_pred_taken,
    output logic            ras_pred_taken
);

    rv_pkg::addr_t pred_target;
    rv_pkg::addr_t pc_redirect_target;
    rv_pkg::addr_t pc_next;

    rv_pc_sel #(
        .RAS_ENABLE(RAS_ENABLE),
        .BTB_ENABLE(BTB_ENABLE)
    ) u_pc_sel (
        .mispredicted_mem      (mispredicted_mem),
        .pc_redirect_target_mem(pc_redirect_target_mem),
        .pc_sel_ex             (pc_sel_ex),
        .pc_redirect_target_ex (pc_redirect_target_ex),
        .pc_sel_id             (pc_sel_id),
        .pred_target_id        (pred_target_id),
        .ras_valid             (ras_valid),
        .ras_target            (ras_target),
        .is_jalr_id            (is_jalr_id),
        .ras_valid_id          (ras_valid_id),
        .ras_target_id         (ras_target_id),
        .btb_hit               (btb_hit),
        .btb_taken             (btb_taken),
        .btb_target            (btb_target),
        .btb_is_return         (btb_is_return),
        .btb_hit_id            (btb_hit_id),
        .btb_is_return_id      (btb_is_return_id),
        .pc_sel                (pc_sel),
        .pred_target           (pred_target),
        .pc_redirect_target    (pc_redirect_target),
        .btb_pred_taken        (btb_pred_taken),
        .ras_pred_taken        (ras_pred_taken)
    );

    // Next-PC mux, anything unrecognised falls through to the sequential word
    always_comb begin
        case (pc_sel)
            rv_pkg::PC_SEL_REDIRECT:  pc_next = pc_redirect_target;
            rv_pkg::PC_SEL_PREDICTED: pc_next = pred_target;
            default:                  pc_next = pc_if + rv_pkg::addr_t'(4);
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_if <= `RV_RESET_PC;
        end else begin
            pc_if <= pc_next;
        end
    end

endmodule

/* rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch #(
    parameter int RAS_ENABLE = 1,
    parameter int BTB_ENABLE = 1
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            mispredicted_mem,
    input  rv_pkg::addr_t   pc_redirect_target_mem,
    input  rv_pkg::pc_sel_t pc_sel_ex,
    input  rv_pkg::addr_t   pc_redirect_target_ex,
    input  rv_pkg::pc_sel_t pc_sel_id,
    input  rv_pkg::addr_t   pred_target_id,
    input  logic            is_jalr_id,
    input  logic            btb_upd_valid,
    input  rv_pkg::addr_t   btb_upd_pc,
    input  rv_pkg::addr_t   btb_upd_target,
    input  logic            btb_upd_taken,
    input  logic            btb_upd_is_return,
    input  logic            ras_push,
    input  rv_pkg::addr_t   ras_push_addr,
    input  logic            ras_pop,
    output rv_pkg::addr_t   pc_if,
    output rv_pkg::pc_sel_t pc_sel,
    output logic            btb_pred_taken,
    output logic            ras_pred_taken,
    output logic            ras_valid
);

    // IF-stage predictor outputs, looked up from the current pc_if
    logic          btb_hit;
    logic          btb_taken;
    rv_pkg::addr_t btb_target;
    logic          btb_is_return;
    rv_pkg::addr_t ras_target;

    // Same context one cycle later, lined up with the instruction in ID
    logic          ras_valid_id;
    rv_pkg::addr_t ras_target_id;
    logic          btb_hit_id;
    logic          btb_is_return_id;

    rv_btb #(
        .BTB_ENABLE(BTB_ENABLE)
    ) u_btb (
        .clk              (clk),
        .arst_n           (arst_n),
        .pc_if            (pc_if),
        .btb_upd_valid    (btb_upd_valid),
        .btb_upd_pc       (btb_upd_pc),
        .btb_upd_target   (btb_upd_target),
        .btb_upd_taken    (btb_upd_taken),
        .btb_upd_is_return(btb_upd_is_return),
        .btb_hit          (btb_hit),
        .btb_taken        (btb_taken),
        .btb_target       (btb_target),
        .btb_is_return    (btb_is_return)
    );

    rv_ras #(
        .RAS_ENABLE(RAS_ENABLE)
    ) u_ras (
        .clk          (clk),
        .arst_n       (arst_n),
        .ras_push     (ras_push),
        .ras_push_addr(ras_push_addr),
        .ras_pop      (ras_pop),
        .ras_valid    (ras_valid),
        .ras_target   (ras_target)
    );

    rv_if_id_buf u_if_id_buf (
        .clk             (clk),
        .arst_n          (arst_n),
        .ras_valid       (ras_valid),
        .ras_target      (ras_target),
        .btb_hit         (btb_hit),
        .btb_is_return   (btb_is_return),
        .ras_valid_id    (ras_valid_id),
        .ras_target_id   (ras_target_id),
        .btb_hit_id      (btb_hit_id),
        .btb_is_return_id(btb_is_return_id)
    );

    rv_pc_gen #(
        .RAS_ENABLE(RAS_ENABLE),
        .BTB_ENABLE(BTB_ENABLE)
    ) u_pc_gen (
        .clk                   (clk),
        .arst_n                (arst_n),
        .mispredicted_mem      (mispredicted_mem),
        .pc_redirect_target_mem(pc_redirect_target_mem),
        .pc_sel_ex             (pc_sel_ex),
        .pc_redirect_target_ex (pc_redirect_target_ex),
        .pc_sel_id             (pc_sel_id),
        .pred_target_id        (pred_target_id),
        .ras_valid             (ras_valid),
        .ras_target            (ras_target),
        .is_jalr_id            (is_jalr_id),
        .ras_valid_id          (ras_valid_id),
        .ras_target_id         (ras_target_id),
        .btb_hit               (btb_hit),
        .btb_taken             (btb_taken),
        .btb_target            (btb_target),
        .btb_is_return         (btb_is_return),
        .btb_hit_id            (btb_hit_id),
        .btb_is_return_id      (btb_is_return_id),
        .pc_if                 (pc_if),
        .pc_sel                (pc_sel),
        .btb_pred_taken        (btb_pred_taken),
        .ras_pred_taken        (ras_pred_taken)
    );

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    // 10 ns period, so each half is 5 ns
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset is held for 10 rising edges and dropped on a falling edge,
    // well away from the edge the flops sample on
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* rv_fetch_chk.sv */
`timescale 1ns/1ps

module rv_fetch_chk (
    input logic            clk,
    input logic            arst_n,
    input rv_pkg::addr_t   pc_if,
    input rv_pkg::pc_sel_t pc_sel,
    input logic            mispredicted_mem,
    input logic            btb_pred_taken,
    input logic            ras_pred_taken
);

    // Every fetch address is a 32-bit instruction word
    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc_if[1:0] == 2'b00)
        else $error("pc_if left word alignment");

    // Only one IF-side source can claim the fetch in a cycle
    a_flags_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(btb_pred_taken && ras_pred_taken))
        else $error("btb_pred_taken and ras_pred_taken were high together");

    // The oldest redirect always wins
    a_mem_redirect: assert property (@(posedge clk) disable iff (!arst_n)
        mispredicted_mem |-> (pc_sel == rv_pkg::PC_SEL_REDIRECT))
        else $error("MEM misprediction did not select the redirect");

endmodule

bind rv_fetch rv_fetch_chk i_chk (
    .clk             (clk),
    .arst_n          (arst_n),
    .pc_if           (pc_if),
    .pc_sel          (pc_sel),
    .mispredicted_mem(mispredicted_mem),
    .btb_pred_taken  (btb_pred_taken),
    .ras_pred_taken  (ras_pred_taken)
);

/* tb_rv_fetch.sv */
`timescale 1ns/1ps

`include "rv_defs.svh"

module tb_rv_fetch;

    localparam int IDX_W         = $clog2(`RV_BTB_ENTRIES);
    localparam int TAG_W         = `RV_XLEN - IDX_W - 2;
    localparam int PTR_W         = $clog2(`RV_RAS_DEPTH);
    localparam int NUM_CYCLES    = 3000;
    localparam int QUIET_CYCLES  = 16;
    localparam int RESET_TIMEOUT = 100;

    logic            clk;
    logic            arst_n;
    logic            mispredicted_mem;
    rv_pkg::addr_t   pc_redirect_target_mem;
    rv_pkg::pc_sel_t pc_sel_ex;
    rv_pkg::addr_t   pc_redirect_target_ex;
    rv_pkg::pc_sel_t pc_sel_id;
    rv_pkg::addr_t   pred_target_id;
    logic            is_jalr_id;
    logic            btb_upd_valid;
    rv_pkg::addr_t   btb_upd_pc;
    rv_pkg::addr_t   btb_upd_target;
    logic            btb_upd_taken;
    logic            btb_upd_is_return;
    logic            ras_push;
    rv_pkg::addr_t   ras_push_addr;
    logic            ras_pop;
    rv_pkg::addr_t   pc_if;
    rv_pkg::pc_sel_t pc_sel;
    logic            btb_pred_taken;
    logic            ras_pred_taken;
    logic            ras_valid;

    // Reference copy of the BTB table
    logic            m_valid  [`RV_BTB_ENTRIES];
    logic [TAG_W-1:0] m_tag   [`RV_BTB_ENTRIES];
    rv_pkg::addr_t   m_target [`RV_BTB_ENTRIES];
    logic [1:0]      m_cnt    [`RV_BTB_ENTRIES];
    logic            m_ret    [`RV_BTB_ENTRIES];

    // Reference RAS, the ID-stage copies and the fetch PC
    rv_pkg::addr_t   m_stack [`RV_RAS_DEPTH];
    int              m_tos;
    int              m_count;
    logic            m_ras_valid_id;
    rv_pkg::addr_t   m_ras_target_id;
    logic            m_btb_hit_id;
    logic            m_btb_ret_id;
    rv_pkg::addr_t   m_pc;

    // What the model expects for the cycle in progress
    logic            e_hit;
    logic            e_taken;
    logic            e_ret;
    rv_pkg::addr_t   e_btb_target;
    logic            e_ras_valid;
    rv_pkg::addr_t   e_ras_top;
    rv_pkg::pc_sel_t e_sel;
    rv_pkg::addr_t   e_next;
    logic            e_btb_flag;
    logic            e_ras_flag;
    int              wait_count;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .arst_n(arst_n)
    );

    rv_fetch #(
        .RAS_ENABLE(1),
        .BTB_ENABLE(1)
    ) i_dut (
        .clk                   (clk),
        .arst_n                (arst_n),
        .mispredicted_mem      (mispredicted_mem),
        .pc_redirect_target_mem(pc_redirect_target_mem),
        .pc_sel_ex             (pc_sel_ex),
        .pc_redirect_target_ex (pc_redirect_target_ex),
        .pc_sel_id             (pc_sel_id),
        .pred_target_id        (pred_target_id),
        .is_jalr_id            (is_jalr_id),
        .btb_upd_valid         (btb_upd_valid),
        .btb_upd_pc            (btb_upd_pc),
        .btb_upd_target        (btb_upd_target),
        .btb_upd_taken         (btb_upd_taken),
        .btb_upd_is_return     (btb_upd_is_return),
        .ras_push              (ras_push),
        .ras_push_addr         (ras_push_addr),
        .ras_pop               (ras_pop),
        .pc_if                 (pc_if),
        .pc_sel                (pc_sel),
        .btb_pred_taken        (btb_pred_taken),
        .ras_pred_taken        (ras_pred_taken),
        .ras_valid             (ras_valid)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp_val, act_val);
        $display("test failed");
        $fatal(1);
    endtask

    // Word-aligned address in the low 256 bytes, so the BTB tags collide often
    function automatic rv_pkg::addr_t region_addr();
        logic [31:0] r;
        r = $urandom;
        return {24'h0, r[7:2], 2'b00};
    endfunction

    task automatic clear_model();
        for (int i = 0; i < `RV_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        m_tos           = 0;
        m_count         = 0;
        m_ras_valid_id  = 1'b0;
        m_ras_target_id = '0;
        m_btb_hit_id    = 1'b0;
        m_btb_ret_id    = 1'b0;
        m_pc            = `RV_RESET_PC;
    endtask

    // Redirects and decode predictions are rare, pushes slightly outnumber pops
    // so the stack also gets driven past its depth
    task automatic drive_random_inputs(input bit quiet);
        mispredicted_mem       = !quiet && (($urandom % 32) == 0);
        pc_redirect_target_mem = region_addr();
        pc_sel_ex              = (!quiet && (($urandom % 16) == 0)) ?
                                 rv_pkg::PC_SEL_REDIRECT : rv_pkg::PC_SEL_SEQ;
        pc_redirect_target_ex  = region_addr();
        pc_sel_id              = (!quiet && (($urandom % 16) == 0)) ?
                                 rv_pkg::PC_SEL_PREDICTED : rv_pkg::PC_SEL_SEQ;
        pred_target_id         = region_addr();
        is_jalr_id             = !quiet && (($urandom % 8) == 0);
        btb_upd_valid          = !quiet && (($urandom % 4) == 0);
        btb_upd_pc             = (($urandom % 2) == 0) ? m_pc : region_addr();
        btb_upd_target         = region_addr();
        btb_upd_taken          = (($urandom % 2) == 0);
        btb_upd_is_return      = (($urandom % 4) == 0);
        ras_push               = !quiet && (($urandom % 4) == 0);
        ras_push_addr          = region_addr();
        ras_pop                = !quiet && (($urandom % 6) == 0);
    endtask

    // Lookup and next-PC choice for the current cycle, from the model state
    task automatic predict_cycle();
        logic [IDX_W-1:0] idx;
        logic             early_pred;
        logic             late_pred;
        logic             btb_pred;
        logic             id_pred;
        idx          = m_pc[IDX_W+1:2];
        e_hit        = m_valid[idx] && (m_tag[idx] == m_pc[`RV_XLEN-1:IDX_W+2]);
        e_taken      = e_hit && (m_cnt[idx] >= 2'd2);
        e_ret        = e_hit && m_ret[idx];
        e_btb_target = m_target[idx];
        e_ras_valid  = (m_count != 0);
        e_ras_top    = e_ras_valid ? m_stack[m_tos[PTR_W-1:0]] : '0;
        // A known return needs a live stack, a missed JALR needs the stack it saw in IF
        early_pred   = e_ret && e_ras_valid;
        late_pred    = is_jalr_id && !(m_btb_hit_id && m_btb_ret_id) && m_ras_valid_id;
        btb_pred     = e_taken;
        id_pred      = (pc_sel_id == rv_pkg::PC_SEL_PREDICTED);
        // Each flag names the IF-side source that actually steers the fetch
        e_ras_flag   = !id_pred && late_pred;
        e_btb_flag   = !id_pred && !late_pred && (btb_pred || early_pred);
        e_sel        = rv_pkg::PC_SEL_PREDICTED;
        if (mispredicted_mem) begin
            e_sel  = rv_pkg::PC_SEL_REDIRECT;
            e_next = pc_redirect_target_mem;
        end else if (pc_sel_ex == rv_pkg::PC_SEL_REDIRECT) begin
            e_sel  = rv_pkg::PC_SEL_REDIRECT;
            e_next = pc_redirect_target_ex;
        end else if (id_pred) begin
            e_next = pred_target_id;
        end else if (late_pred) begin
            // A JALR that IF missed uses the top it was fetched against
            e_next = m_ras_target_id;
        end else if (early_pred) begin
            e_next = e_ras_top;
        end else if (btb_pred) begin
            e_next = e_btb_target;
        end else begin
            e_sel  = rv_pkg::PC_SEL_SEQ;
            e_next = m_pc + 32'd4;
        end
    endtask

    // State change at the rising edge, using the inputs that edge sampled
    task automatic advance_model();
        logic [IDX_W-1:0] uidx;
        logic [TAG_W-1:0] utag;
        logic             pop_ok;
        if (btb_upd_valid) begin
            uidx = btb_upd_pc[IDX_W+1:2];
            utag = btb_upd_pc[`RV_XLEN-1:IDX_W+2];
            if (!(m_valid[uidx] && (m_tag[uidx] == utag))) begin
                m_cnt[uidx] = 2'd2;
            end else if (btb_upd_taken && (m_cnt[uidx] != 2'd3)) begin
                m_cnt[uidx] = m_cnt[uidx] + 2'd1;
            end else if (!btb_upd_taken && (m_cnt[uidx] != 2'd0)) begin
                m_cnt[uidx] = m_cnt[uidx] - 2'd1;
            end
            m_valid[uidx]  = 1'b1;
            m_tag[uidx]    = utag;
            m_target[uidx] = btb_upd_target;
            m_ret[uidx]    = btb_upd_is_return;
        end
        pop_ok = ras_pop && (m_count != 0);
        if (ras_push && !pop_ok) begin
            m_tos = (m_tos + 1) % `RV_RAS_DEPTH;
            m_stack[m_tos[PTR_W-1:0]] = ras_push_addr;
            if (m_count < `RV_RAS_DEPTH) begin
                m_count++;
            end
        end else if (pop_ok && !ras_push) begin
            m_tos = (m_tos + `RV_RAS_DEPTH - 1) % `RV_RAS_DEPTH;
            m_count--;
        end else if (ras_push && pop_ok) begin
            m_stack[m_tos[PTR_W-1:0]] = ras_push_addr;
        end
        m_ras_valid_id  = e_ras_valid;
        m_ras_target_id = e_ras_top;
        m_btb_hit_id    = e_hit;
        m_btb_ret_id    = e_ret;
        m_pc            = e_next;
    endtask

    initial begin
        void'($urandom(32'h3454ac0f));
        mispredicted_mem       = 1'b0;
        pc_redirect_target_mem = '0;
        pc_sel_ex              = rv_pkg::PC_SEL_SEQ;
        pc_redirect_target_ex  = '0;
        pc_sel_id              = rv_pkg::PC_SEL_SEQ;
        pred_target_id         = '0;
        is_jalr_id             = 1'b0;
        btb_upd_valid          = 1'b0;
        btb_upd_pc             = '0;
        btb_upd_target         = '0;
        btb_upd_taken          = 1'b0;
        btb_upd_is_return      = 1'b0;
        ras_push               = 1'b0;
        ras_push_addr          = '0;
        ras_pop                = 1'b0;
        clear_model();

        wait_count = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            wait_count++;
            if (wait_count > RESET_TIMEOUT) begin
                stop_with_failure("Reset was never released");
            end
        end
        // The first edge out of reset already stepped the PC with idle inputs
        predict_cycle();
        advance_model();

        // The first cycles stay idle so the PC just walks from the reset value
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge clk);
            assert (pc_if == m_pc)
                else report_mismatch("pc_if", m_pc, pc_if);
            assert (ras_valid == (m_count != 0))
                else report_mismatch("ras_valid", 32'(m_count != 0), 32'(ras_valid));
            drive_random_inputs(cyc < QUIET_CYCLES);
            #1;
            predict_cycle();
            assert (pc_sel == e_sel)
                else report_mismatch("pc_sel", 32'(e_sel), 32'(pc_sel));
            assert (btb_pred_taken == e_btb_flag)
                else report_mismatch("btb_pred_taken", 32'(e_btb_flag), 32'(btb_pred_taken));
            assert (ras_pred_taken == e_ras_flag)
                else report_mismatch("ras_pred_taken", 32'(e_ras_flag), 32'(ras_pred_taken));
            @(posedge clk);
            advance_model();
        end

        $display("test passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
rv_pkg.sv
rv_btb.sv
rv_ras.sv
rv_if_id_buf.sv
rv_pc_sel.sv
rv_pc_gen.sv
rv_fetch.sv
tb_clk_gen.sv
rv_fetch_chk.sv
tb_rv_fetch.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_fetch
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
